/* apb_mbox_top.f */
verilog/apb_mbox_pkg.sv
verilog/apb_slv_sif.sv
verilog/mbox_fifo.sv
verilog/mbox_sram.sv
verilog/mbox_regs.sv
verilog/apb_mbox_top.sv
tests/apb_mbox_assert.sv
tests/apb_mbox_tb.sv

/* Bender.yml */
package:
  name: apb_mbox

sources:
  - files:
      - verilog/apb_mbox_pkg.sv
      - verilog/apb_slv_sif.sv
      - verilog/mbox_fifo.sv
      - verilog/mbox_sram.sv
      - verilog/mbox_regs.sv
      - verilog/apb_mbox_top.sv
  - target: test
    files:
      - tests/apb_mbox_assert.sv
      - tests/apb_mbox_tb.sv

/* tests/apb_mbox_tb.sv */
/*
 * apb mailbox testbench
 * drives apb transfers and compares every response with a reference model
 */

`timescale 1ns/1ps

module apb_mbox_tb;

   localparam int          N_SCRATCH   = 8;
   localparam int          N_SRAM_RD   = 64;
   localparam int          N_ERR_XFERS = 19;
   localparam int          N_MIX       = 200;
   localparam int          MAX_WAITS   = 4;
   localparam logic [31:0] SEED        = 32'h18b3_1adf;
   // every transfer the tests issue, counted per test
   localparam int N_XFERS = 1 + 2 * N_SCRATCH + 4 * apb_mbox_pkg::MBOX_FIFO_DEPTH + 5 +
                            apb_mbox_pkg::MBOX_SRAM_WORDS + N_SRAM_RD + N_ERR_XFERS + N_MIX;
   // worst case four cycles per transfer plus reset and slack
   localparam int WATCHDOG_NS = N_XFERS * 4 * 8 + 1000;

   logic                                PCLK;
   logic                                PRESETn;
   logic [apb_mbox_pkg::ADDR_WIDTH-1:0] PADDR;
   logic [2:0]                          PPROT;
   logic                                PSEL;
   logic                                PENABLE;
   logic                                PWRITE;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] PWDATA;
   logic [apb_mbox_pkg::USER_WIDTH-1:0] PAUSER;
   logic                                PREADY;
   logic                                PSLVERR;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] PRDATA;

   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          tests_run;

   // reference model state
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] m_scratch;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] m_fifo [$];
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] m_sram [apb_mbox_pkg::MBOX_SRAM_WORDS];

   // last finished transfer, handed to the compare process
   logic                                req_write;
   logic [apb_mbox_pkg::ADDR_WIDTH-1:0] req_addr;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] req_wdata;
   logic [apb_mbox_pkg::USER_WIDTH-1:0] req_user;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] obs_rdata;
   logic                                obs_err;
   int                                  obs_waits;
   event                                xfer_done;

   apb_mbox_top i_apb_mbox_top (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .PADDR   (PADDR),
      .PPROT   (PPROT),
      .PSEL    (PSEL),
      .PENABLE (PENABLE),
      .PWRITE  (PWRITE),
      .PWDATA  (PWDATA),
      .PAUSER  (PAUSER),
      .PREADY  (PREADY),
      .PSLVERR (PSLVERR),
      .PRDATA  (PRDATA)
   );

   initial begin
      PCLK = 1'b0;
      forever #4 PCLK = ~PCLK;
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
         end
         v = {v[30:0], b};
      end
      return v;
   endfunction

   function automatic logic [apb_mbox_pkg::ADDR_WIDTH-1:0] sram_addr(input int idx);
      return apb_mbox_pkg::ADDR_WIDTH'(apb_mbox_pkg::ADDR_SRAM_BASE + idx * 4);
   endfunction

   // target of an address per the register map
   function automatic apb_mbox_pkg::mbox_reg_e decode(input logic [11:0] a);
      if (a[1:0] != 2'b00) begin
         return apb_mbox_pkg::REG_NONE;
      end
      if (a >= apb_mbox_pkg::ADDR_SRAM_BASE &&
          a < apb_mbox_pkg::ADDR_SRAM_BASE + 4 * apb_mbox_pkg::MBOX_SRAM_WORDS) begin
         return apb_mbox_pkg::REG_SRAM;
      end
      case (a)
         apb_mbox_pkg::ADDR_ID:      return apb_mbox_pkg::REG_ID;
         apb_mbox_pkg::ADDR_SCRATCH: return apb_mbox_pkg::REG_SCRATCH;
         apb_mbox_pkg::ADDR_FIFO:    return apb_mbox_pkg::REG_FIFO;
         apb_mbox_pkg::ADDR_STATUS:  return apb_mbox_pkg::REG_STATUS;
         apb_mbox_pkg::ADDR_CTRL:    return apb_mbox_pkg::REG_CTRL;
         default:                    return apb_mbox_pkg::REG_NONE;
      endcase
   endfunction

   // expected response of one transfer, updates the model state on success
   function automatic void model_access(input logic wr, input logic [11:0] a,
                                        input logic [31:0] wd, input logic [7:0] usr,
                                        output logic [31:0] rd, output logic err,
                                        output int waits);
      int idx;
      rd    = '0;
      err   = 1'b0;
      waits = 0;
      idx   = (a - apb_mbox_pkg::ADDR_SRAM_BASE) >> 2;
      case (decode(a))
         apb_mbox_pkg::REG_ID: begin
            if (wr) err = 1'b1;
            else rd = apb_mbox_pkg::MBOX_ID;
         end
         apb_mbox_pkg::REG_SCRATCH: begin
            if (wr) m_scratch = wd;
            else rd = m_scratch;
         end
         apb_mbox_pkg::REG_FIFO: begin
            if (wr && m_fifo.size() == apb_mbox_pkg::MBOX_FIFO_DEPTH) err = 1'b1;
            else if (wr) m_fifo.push_back(wd);
            else if (m_fifo.size() == 0) err = 1'b1;
            else rd = m_fifo.pop_front();
         end
         apb_mbox_pkg::REG_STATUS: begin
            if (wr) begin
               err = 1'b1;
            end else begin
               rd[3:0] = 4'(m_fifo.size());
               rd[8]   = (m_fifo.size() == 0);
               rd[9]   = (m_fifo.size() == apb_mbox_pkg::MBOX_FIFO_DEPTH);
            end
         end
         apb_mbox_pkg::REG_CTRL: begin
            // privileged write, flush bit is write-only
            if (wr && usr != apb_mbox_pkg::MBOX_ADMIN_USER) err = 1'b1;
            else if (wr && wd[0]) m_fifo.delete();
         end
         apb_mbox_pkg::REG_SRAM: begin
            if (wr) begin
               m_sram[idx] = wd;
            end else begin
               rd    = m_sram[idx];
               waits = 1;
            end
         end
         default: err = 1'b1;
      endcase
   endfunction

   task automatic log_error(input string msg);
      $display("** Error at %0t: %s", $time, msg);
      errors++;
   endtask

   // compare each finished transfer with the model
   always @(xfer_done) begin : compare
      logic [31:0] exp_rdata;
      logic        exp_err;
      int          exp_waits;
      model_access(req_write, req_addr, req_wdata, req_user, exp_rdata, exp_err, exp_waits);
      checks++;
      assert (obs_err === exp_err)
         else log_error($sformatf("addr %h write %0b PSLVERR %b expected %b",
                                  req_addr, req_write, obs_err, exp_err));
      assert (obs_waits == exp_waits)
         else log_error($sformatf("addr %h write %0b wait cycles %0d expected %0d",
                                  req_addr, req_write, obs_waits, exp_waits));
      // read data is defined on reads and on refused writes, which return zero
      assert ((req_write && !exp_err) || obs_rdata === exp_rdata)
         else log_error($sformatf("addr %h write %0b PRDATA %h expected %h",
                                  req_addr, req_write, obs_rdata, exp_rdata));
   end

   // one transfer starting 1 ns after an edge, leaves the bus in its last access state
   task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] wd,
                           input logic [7:0] usr);
      int waits;
      waits   = 0;
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = wr;
      PADDR   = a;
      PWDATA  = wd;
      PAUSER  = usr;
      @(posedge PCLK);
      #1;
      PENABLE = 1'b1;
      // sample mid-cycle where outputs are settled
      @(negedge PCLK);
      while (!PREADY && waits < MAX_WAITS) begin
         waits++;
         @(negedge PCLK);
      end
      if (!PREADY) begin
         $display("transfer to address %h at %0t never saw PREADY", a, $time);
         errors++;
      end
      req_write = wr;
      req_addr  = a;
      req_wdata = wd;
      req_user  = usr;
      obs_rdata = PRDATA;
      obs_err   = PSLVERR;
      obs_waits = waits;
      -> xfer_done;
      @(posedge PCLK);
      #1;
   endtask

   task automatic go_idle();
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      @(posedge PCLK);
      #1;
   endtask

   task automatic apb_write(input logic [11:0] a, input logic [31:0] wd, input logic [7:0] usr);
      apb_xfer(1'b1, a, wd, usr);
      go_idle();
   endtask

   task automatic apb_read(input logic [11:0] a);
      apb_xfer(1'b0, a, '0, 8'h00);
      go_idle();
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) $display("test %s ok", name);
      else $display("test %s FAILED with %0d errors", name, errors - errs_before);
   endtask

   task automatic test_id_scratch();
      int e0;
      e0 = errors;
      apb_read(apb_mbox_pkg::ADDR_ID);
      for (int i = 0; i < N_SCRATCH; i++) begin
         apb_write(apb_mbox_pkg::ADDR_SCRATCH, rand_bits(32), 8'h00);
         apb_read(apb_mbox_pkg::ADDR_SCRATCH);
      end
      report_test("id_scratch", e0);
   endtask

   task automatic test_fifo();
      int e0;
      e0 = errors;
      apb_read(apb_mbox_pkg::ADDR_STATUS);
      for (int i = 0; i < apb_mbox_pkg::MBOX_FIFO_DEPTH; i++) begin
         apb_write(apb_mbox_pkg::ADDR_FIFO, rand_bits(32), 8'h00);
         apb_read(apb_mbox_pkg::ADDR_STATUS);
      end
      // one push too many
      apb_write(apb_mbox_pkg::ADDR_FIFO, rand_bits(32), 8'h00);
      apb_read(apb_mbox_pkg::ADDR_STATUS);
      for (int i = 0; i < apb_mbox_pkg::MBOX_FIFO_DEPTH; i++) begin
         apb_read(apb_mbox_pkg::ADDR_FIFO);
         apb_read(apb_mbox_pkg::ADDR_STATUS);
      end
      // pop from an empty fifo
      apb_read(apb_mbox_pkg::ADDR_FIFO);
      apb_read(apb_mbox_pkg::ADDR_STATUS);
      report_test("fifo", e0);
   endtask

   task automatic test_sram();
      int e0;
      e0 = errors;
      // fill every word so later reads are defined
      for (int i = 0; i < apb_mbox_pkg::MBOX_SRAM_WORDS; i++) begin
         apb_write(sram_addr(i), rand_bits(32), 8'h00);
      end
      for (int i = 0; i < N_SRAM_RD; i++) begin
         apb_read(sram_addr(rand_bits(6)));
      end
      report_test("sram", e0);
   endtask

   task automatic test_errors();
      int e0;
      e0 = errors;
      // unmapped
      apb_read(12'h014);
      apb_read(12'h0fc);
      apb_read(12'h200);
      apb_write(12'h020, rand_bits(32), apb_mbox_pkg::MBOX_ADMIN_USER);
      // misaligned, scratch must keep its value
      apb_read(12'h005);
      apb_read(12'h102);
      apb_write(12'h006, rand_bits(32), apb_mbox_pkg::MBOX_ADMIN_USER);
      apb_read(apb_mbox_pkg::ADDR_SCRATCH);
      // read-only registers
      apb_write(apb_mbox_pkg::ADDR_ID, rand_bits(32), apb_mbox_pkg::MBOX_ADMIN_USER);
      apb_read(apb_mbox_pkg::ADDR_ID);
      apb_write(apb_mbox_pkg::ADDR_STATUS, rand_bits(32), apb_mbox_pkg::MBOX_ADMIN_USER);
      for (int i = 0; i < 3; i++) begin
         apb_write(apb_mbox_pkg::ADDR_FIFO, rand_bits(32), 8'h00);
      end
      // flush from an ordinary user is refused
      apb_write(apb_mbox_pkg::ADDR_CTRL, 32'h1, 8'h3c);
      apb_read(apb_mbox_pkg::ADDR_STATUS);
      apb_read(apb_mbox_pkg::ADDR_CTRL);
      apb_write(apb_mbox_pkg::ADDR_CTRL, 32'h1, apb_mbox_pkg::MBOX_ADMIN_USER);
      apb_read(apb_mbox_pkg::ADDR_STATUS);
      report_test("errors", e0);
   endtask

   // back-to-back transfers, no idle cycle in between
   task automatic test_mix();
      int                                  e0;
      logic [2:0]                          sel;
      logic                                wr;
      logic [apb_mbox_pkg::ADDR_WIDTH-1:0] a;
      logic [apb_mbox_pkg::USER_WIDTH-1:0] usr;
      e0 = errors;
      for (int i = 0; i < N_MIX; i++) begin
         sel = 3'(rand_bits(3));
         wr  = 1'(rand_bits(1));
         if (rand_bits(1)) usr = apb_mbox_pkg::MBOX_ADMIN_USER;
         else usr = 8'(rand_bits(8));
         case (sel)
            3'd0:       a = apb_mbox_pkg::ADDR_ID;
            3'd1:       a = apb_mbox_pkg::ADDR_SCRATCH;
            3'd2, 3'd3: a = apb_mbox_pkg::ADDR_FIFO;
            3'd4:       a = apb_mbox_pkg::ADDR_STATUS;
            3'd5:       a = apb_mbox_pkg::ADDR_CTRL;
            3'd6:       a = sram_addr(rand_bits(6));
            default:    a = 12'(rand_bits(12));
         endcase
         apb_xfer(wr, a, rand_bits(32), usr);
      end
      go_idle();
      report_test("mix", e0);
   endtask

   initial begin
      int total;
      PRESETn   = 1'b0;
      PADDR     = '0;
      PPROT     = 3'b000;
      PSEL      = 1'b0;
      PENABLE   = 1'b0;
      PWRITE    = 1'b0;
      PWDATA    = '0;
      PAUSER    = '0;
      lfsr      = SEED;
      errors    = 0;
      checks    = 0;
      tests_run = 0;
      m_scratch = '0;
      repeat (5) @(posedge PCLK);
      #1;
      PRESETn = 1'b1;
      @(posedge PCLK);
      #1;
      test_id_scratch();
      test_fifo();
      test_sram();
      test_errors();
      test_mix();
      total = errors + i_apb_mbox_top.i_apb_slv_sif.i_apb_mbox_assert.fails;
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total);
      if (total == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

endmodule

/* tests/apb_mbox_assert.sv */
/*
 * apb protocol checks bound into the slave adapter
 */

`timescale 1ns/1ps

module apb_mbox_assert (
   input logic                                PCLK,
   input logic                                PRESETn,
   input logic                                PSEL,
   input logic                                PENABLE,
   input logic                                PREADY,
   input logic                                PSLVERR,
   input logic                                dv,
   input logic [apb_mbox_pkg::ADDR_WIDTH-1:0] addr
);

   // failure count, read by the testbench at the end
   int fails = 0;

   // idle and setup cycles look ready and error free
   quiet_outside_access: assert property (@(posedge PCLK) disable iff (!PRESETn)
      !(PSEL && PENABLE) |-> PREADY && !PSLVERR)
      else begin
         $error("PREADY low or PSLVERR high outside an access phase");
         fails++;
      end

   setup_before_access: assert property (@(posedge PCLK) disable iff (!PRESETn)
      $rose(PSEL && PENABLE) |-> $past(PSEL && !PENABLE))
      else begin
         $error("access phase started without a setup phase");
         fails++;
      end

   // completed access must not linger into the next cycle
   access_ends: assert property (@(posedge PCLK) disable iff (!PRESETn)
      dv && PSEL && PENABLE && PREADY |=> !PENABLE && !dv)
      else begin
         $error("access phase continued after completing with PREADY");
         fails++;
      end

   addr_stable: assert property (@(posedge PCLK) disable iff (!PRESETn)
      dv && $past(dv) |-> $stable(addr))
      else begin
         $error("latched address changed while dv was high");
         fails++;
      end

endmodule

bind apb_slv_sif apb_mbox_assert i_apb_mbox_assert (
   .PCLK    (PCLK),
   .PRESETn (PRESETn),
   .PSEL    (PSEL),
   .PENABLE (PENABLE),
   .PREADY  (PREADY),
   .PSLVERR (PSLVERR),
   .dv      (dv),
   .addr    (addr)
);

/* verilog/apb_mbox_top.sv */
/*
 * apb mailbox peripheral
 * adapter, register block, data fifo and sram window
 */

`timescale 1ns/1ps

module apb_mbox_top (
   input  logic                                PCLK,
   input  logic                                PRESETn,
   input  logic [apb_mbox_pkg::ADDR_WIDTH-1:0] PADDR,
   input  logic [2:0]                          PPROT,
   input  logic                                PSEL,
   input  logic                                PENABLE,
   input  logic                                PWRITE,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0] PWDATA,
   input  logic [apb_mbox_pkg::USER_WIDTH-1:0] PAUSER,
   output logic                                PREADY,
   output logic                                PSLVERR,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0] PRDATA
);

   // adapter to register block
   logic                                    dv;
   logic                                    write;
   logic [apb_mbox_pkg::ADDR_WIDTH-1:0]     addr;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     wdata;
   logic [apb_mbox_pkg::USER_WIDTH-1:0]     user;
   logic                                    hold;
   logic                                    slverr;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     rdata;

   // register block to fifo
   logic                                    fifo_push;
   logic                                    fifo_pop;
   logic                                    fifo_flush;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     fifo_push_data;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     fifo_pop_data;
   logic [apb_mbox_pkg::MBOX_CNT_WIDTH-1:0] fifo_count;
   logic                                    fifo_empty;
   logic                                    fifo_full;

   // register block to sram
   logic                                    sram_en;
   logic                                    sram_we;
   logic [apb_mbox_pkg::MBOX_SRAM_AW-1:0]   sram_index;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     sram_wdata;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0]     sram_rdata;

   apb_slv_sif i_apb_slv_sif (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .PADDR   (PADDR),
      .PPROT   (PPROT),
      .PSEL    (PSEL),
      .PENABLE (PENABLE),
      .PWRITE  (PWRITE),
      .PWDATA  (PWDATA),
      .PAUSER  (PAUSER),
      .PREADY  (PREADY),
      .PSLVERR (PSLVERR),
      .PRDATA  (PRDATA),
      .dv      (dv),
      .hold    (hold),
      .write   (write),
      .user    (user),
      .wdata   (wdata),
      .addr    (addr),
      .slverr  (slverr),
      .rdata   (rdata)
   );

   mbox_regs i_mbox_regs (
      .PCLK           (PCLK),
      .PRESETn        (PRESETn),
      .dv             (dv),
      .write          (write),
      .addr           (addr),
      .wdata          (wdata),
      .user           (user),
      .hold           (hold),
      .slverr         (slverr),
      .rdata          (rdata),
      .fifo_pop_data  (fifo_pop_data),
      .fifo_count     (fifo_count),
      .fifo_empty     (fifo_empty),
      .fifo_full      (fifo_full),
      .fifo_push      (fifo_push),
      .fifo_pop       (fifo_pop),
      .fifo_flush     (fifo_flush),
      .fifo_push_data (fifo_push_data),
      .sram_rdata     (sram_rdata),
      .sram_en        (sram_en),
      .sram_we        (sram_we),
      .sram_index     (sram_index),
      .sram_wdata     (sram_wdata)
   );

   mbox_fifo i_mbox_fifo (
      .PCLK      (PCLK),
      .PRESETn   (PRESETn),
      .push      (fifo_push),
      .pop       (fifo_pop),
      .flush     (fifo_flush),
      .push_data (fifo_push_data),
      .pop_data  (fifo_pop_data),
      .count     (fifo_count),
      .empty     (fifo_empty),
      .full      (fifo_full)
   );

   mbox_sram i_mbox_sram (
      .PCLK  (PCLK),
      .en    (sram_en),
      .we    (sram_we),
      .index (sram_index),
      .wdata (sram_wdata),
      .rdata (sram_rdata)
   );

endmodule

/* verilog/mbox_regs.sv */
/*
 * mailbox register block
 * decodes each transfer, checks access rules and drives fifo and sram strobes
 */

`timescale 1ns/1ps

module mbox_regs (
   input  logic                                    PCLK,
   input  logic                                    PRESETn,
   // adapter side
   input  logic                                    dv,
   input  logic                                    write,
   input  logic [apb_mbox_pkg::ADDR_WIDTH-1:0]     addr,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]     wdata,
   input  logic [apb_mbox_pkg::USER_WIDTH-1:0]     user,
   output logic                                    hold,
   output logic                                    slverr,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]     rdata,
   // fifo side
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]     fifo_pop_data,
   input  logic [apb_mbox_pkg::MBOX_CNT_WIDTH-1:0] fifo_count,
   input  logic                                    fifo_empty,
   input  logic                                    fifo_full,
   output logic                                    fifo_push,
   output logic                                    fifo_pop,
   output logic                                    fifo_flush,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]     fifo_push_data,
   // sram side
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]     sram_rdata,
   output logic                                    sram_en,
   output logic                                    sram_we,
   output logic [apb_mbox_pkg::MBOX_SRAM_AW-1:0]   sram_index,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]     sram_wdata
);

   apb_mbox_pkg::mbox_reg_e sel;

   logic                                err;
   logic                                commit;
   logic                                sram_rd;
   logic                                sram_pending;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] scratch;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] status_word;
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] read_word;

   // address decode, misaligned addresses fall to none
   always_comb begin
      sel = apb_mbox_pkg::REG_NONE;
      if (addr[1:0] == 2'b00) begin
         if (addr >= apb_mbox_pkg::ADDR_SRAM_BASE && addr <= apb_mbox_pkg::ADDR_SRAM_LAST) begin
            sel = apb_mbox_pkg::REG_SRAM;
         end else begin
            case (addr)
               apb_mbox_pkg::ADDR_ID:      sel = apb_mbox_pkg::REG_ID;
               apb_mbox_pkg::ADDR_SCRATCH: sel = apb_mbox_pkg::REG_SCRATCH;
               apb_mbox_pkg::ADDR_FIFO:    sel = apb_mbox_pkg::REG_FIFO;
               apb_mbox_pkg::ADDR_STATUS:  sel = apb_mbox_pkg::REG_STATUS;
               apb_mbox_pkg::ADDR_CTRL:    sel = apb_mbox_pkg::REG_CTRL;
               default:                    sel = apb_mbox_pkg::REG_NONE;
            endcase
         end
      end
   end

   // access rule checks
   always_comb begin
      case (sel)
         apb_mbox_pkg::REG_ID:     err = write;
         apb_mbox_pkg::REG_STATUS: err = write;
         // overflow on push, underflow on pop
         apb_mbox_pkg::REG_FIFO:   err = write ? fifo_full : fifo_empty;
         // privileged write only, reads are open
         apb_mbox_pkg::REG_CTRL:   err = write && (user != apb_mbox_pkg::MBOX_ADMIN_USER);
         apb_mbox_pkg::REG_NONE:   err = 1'b1;
         default:                  err = 1'b0;
      endcase
   end

   assign sram_rd = (sel == apb_mbox_pkg::REG_SRAM) && !write;
   // first cycle of an sram read waits for the registered word
   assign hold    = dv && sram_rd && !sram_pending;
   // single commit point per transfer
   assign commit  = dv && !hold && !err;
   assign slverr  = err;

   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         scratch      <= '0;
         sram_pending <= 1'b0;
      end else begin
         // set during the wait cycle, cleared as the read completes
         sram_pending <= hold;
         if (commit && write && sel == apb_mbox_pkg::REG_SCRATCH) begin
            scratch <= wdata;
         end
      end
   end

   // status word assembly
   always_comb begin
      status_word = '0;
      status_word[apb_mbox_pkg::MBOX_CNT_WIDTH-1:0] = fifo_count;
      status_word[apb_mbox_pkg::STATUS_EMPTY_BIT]   = fifo_empty;
      status_word[apb_mbox_pkg::STATUS_FULL_BIT]    = fifo_full;
   end

   // read mux, ctrl reads as zero
   always_comb begin
      case (sel)
         apb_mbox_pkg::REG_ID:      read_word = apb_mbox_pkg::MBOX_ID;
         apb_mbox_pkg::REG_SCRATCH: read_word = scratch;
         apb_mbox_pkg::REG_FIFO:    read_word = fifo_pop_data;
         apb_mbox_pkg::REG_STATUS:  read_word = status_word;
         apb_mbox_pkg::REG_SRAM:    read_word = sram_rdata;
         default:                   read_word = '0;
      endcase
   end

   // errored transfers return zero
   assign rdata = err ? '0 : read_word;

   // fifo strobes at commit only
   assign fifo_push      = commit && write && (sel == apb_mbox_pkg::REG_FIFO);
   assign fifo_pop       = commit && !write && (sel == apb_mbox_pkg::REG_FIFO);
   assign fifo_flush     = commit && write && (sel == apb_mbox_pkg::REG_CTRL) &&
                           wdata[apb_mbox_pkg::CTRL_FLUSH_BIT];
   assign fifo_push_data = wdata;

   // sram write at commit, read launched in the wait cycle
   assign sram_we    = commit && write && (sel == apb_mbox_pkg::REG_SRAM);
   assign sram_en    = sram_we || hold;
   assign sram_index = addr[apb_mbox_pkg::MBOX_SRAM_AW+1:2];
   assign sram_wdata = wdata;

endmodule

/* verilog/mbox_sram.sv */
/*
 * mailbox sram window
 * single-port word array with registered read
 */

`timescale 1ns/1ps

module mbox_sram (
   input  logic                                  PCLK,
   input  logic                                  en,
   input  logic                                  we,
   input  logic [apb_mbox_pkg::MBOX_SRAM_AW-1:0] index,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]   wdata,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]   rdata
);

   // contents undefined after reset
   logic [apb_mbox_pkg::DATA_WIDTH-1:0] mem [apb_mbox_pkg::MBOX_SRAM_WORDS];

   always_ff @(posedge PCLK) begin
      if (en) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            // read word valid the cycle after en
            rdata <= mem[index];
         end
      end
   end

endmodule

/* verilog/mbox_fifo.sv */
/*
 * mailbox data fifo
 * circular buffer with push, pop, flush and occupancy count
 */

`timescale 1ns/1ps

module mbox_fifo (
   input  logic                                    PCLK,
   input  logic                                    PRESETn,
   input  logic                                    push,
   input  logic                                    pop,
   input  logic                                    flush,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]     push_data,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]     pop_data,
   output logic [apb_mbox_pkg::MBOX_CNT_WIDTH-1:0] count,
   output logic                                    empty,
   output logic                                    full
);

   logic [apb_mbox_pkg::DATA_WIDTH-1:0]   mem [apb_mbox_pkg::MBOX_FIFO_DEPTH];
   logic [apb_mbox_pkg::MBOX_FIFO_AW-1:0] wr_ptr;
   logic [apb_mbox_pkg::MBOX_FIFO_AW-1:0] rd_ptr;
   logic                                  do_push;
   logic                                  do_pop;

   // guard against overflow and underflow
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // pointer and count update, flush wins
   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            // depth is a power of two so the pointer wraps naturally
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   // storage, no reset on payload
   always_ff @(posedge PCLK) begin
      if (do_push && !flush) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // head of queue shown combinationally
   assign pop_data = mem[rd_ptr];

   assign empty = (count == '0);
   assign full  = (count == apb_mbox_pkg::MBOX_CNT_WIDTH'(apb_mbox_pkg::MBOX_FIFO_DEPTH));

endmodule

/* verilog/apb_slv_sif.sv */
/*
 * apb slave adapter
 * latches the setup phase and presents one valid strobe per access phase
 */

`timescale 1ns/1ps

module apb_slv_sif (
   // apb side
   input  logic                                   PCLK,
   input  logic                                   PRESETn,
   input  logic [apb_mbox_pkg::ADDR_WIDTH-1:0]    PADDR,
   // protection attribute accepted but not decoded
   input  logic [2:0]                             PPROT,
   input  logic                                   PSEL,
   input  logic                                   PENABLE,
   input  logic                                   PWRITE,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]    PWDATA,
   input  logic [apb_mbox_pkg::USER_WIDTH-1:0]    PAUSER,
   output logic                                   PREADY,
   output logic                                   PSLVERR,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]    PRDATA,

   // component side
   output logic                                   dv,
   input  logic                                   hold,
   output logic                                   write,
   output logic [apb_mbox_pkg::USER_WIDTH-1:0]    user,
   output logic [apb_mbox_pkg::DATA_WIDTH-1:0]    wdata,
   output logic [apb_mbox_pkg::ADDR_WIDTH-1:0]    addr,
   input  logic                                   slverr,
   input  logic [apb_mbox_pkg::DATA_WIDTH-1:0]    rdata
);

   logic setup_phase;
   logic access_phase;
   logic valid_access;

   // first cycle of a transfer
   assign setup_phase  = PSEL & ~PENABLE;
   // every cycle of the access phase, including wait states
   assign access_phase = PSEL & PENABLE;
   // access that was announced by a setup
   assign valid_access = dv & access_phase;

   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         addr  <= '0;
         write <= 1'b0;
         wdata <= '0;
         user  <= '0;
         dv    <= 1'b0;
      end else begin
         // capture attributes at the end of setup
         if (setup_phase) begin
            addr  <= PADDR;
            write <= PWRITE;
            user  <= PAUSER;
         end
         // write data only matters for writes
         if (setup_phase && PWRITE) begin
            wdata <= PWDATA;
         end
         // raise after setup, drop once the access completes with ready
         if (setup_phase) begin
            dv <= 1'b1;
         end else if (access_phase && PREADY) begin
            dv <= 1'b0;
         end
      end
   end

   // component hold stretches the access phase
   assign PREADY  = valid_access ? ~hold : 1'b1;
   assign PRDATA  = valid_access ? rdata : '0;
   // access without a preceding setup is flagged as an error
   assign PSLVERR = valid_access ? slverr : access_phase;

endmodule

/* verilog/apb_mbox_pkg.sv */
/*
 * apb mailbox shared definitions
 * widths, register map, fifo and sram sizing, decoded target type
 */

package apb_mbox_pkg;

   // bus widths
   localparam int ADDR_WIDTH = 12;
   localparam int DATA_WIDTH = 32;
   localparam int USER_WIDTH = 8;

   // identification value returned by the id register
   localparam logic [DATA_WIDTH-1:0] MBOX_ID = 32'h4d42_0100;

   // only this user attribute may write ctrl
   localparam logic [USER_WIDTH-1:0] MBOX_ADMIN_USER = 8'ha5;

   // fifo sizing
   // count needs one extra bit to reach the full value
   localparam int MBOX_FIFO_DEPTH = 8;
   localparam int MBOX_FIFO_AW    = 3;
   localparam int MBOX_CNT_WIDTH  = 4;

   // sram window sizing, one word per 4 byte slot
   localparam int MBOX_SRAM_WORDS = 64;
   localparam int MBOX_SRAM_AW    = 6;

   // register offsets
   localparam logic [ADDR_WIDTH-1:0] ADDR_ID        = 12'h000;
   localparam logic [ADDR_WIDTH-1:0] ADDR_SCRATCH   = 12'h004;
   localparam logic [ADDR_WIDTH-1:0] ADDR_FIFO      = 12'h008;
   localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS    = 12'h00C;
   localparam logic [ADDR_WIDTH-1:0] ADDR_CTRL      = 12'h010;
   localparam logic [ADDR_WIDTH-1:0] ADDR_SRAM_BASE = 12'h100;
   // last word of the sram window
   localparam logic [ADDR_WIDTH-1:0] ADDR_SRAM_LAST = 12'h1FC;

   // status layout
   // count sits in the low bits, flags above
   localparam int STATUS_EMPTY_BIT = 8;
   localparam int STATUS_FULL_BIT  = 9;

   // ctrl layout, flush is write-only
   localparam int CTRL_FLUSH_BIT = 0;

   // decoded target of the current transfer
   typedef enum logic [2:0] {
      REG_ID,
      REG_SCRATCH,
      REG_FIFO,
      REG_STATUS,
      REG_CTRL,
      REG_SRAM,
      REG_NONE
   } mbox_reg_e;

endpackage
